// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --assert --timing -j 0
TOP       = tb_s1c88
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o sim_$(TOP) -f $(FLIST)
	-./$(OBJ_DIR)/sim_$(TOP) | tee $(LOG)
	@grep -q ">>> PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: flist.f
rtl/s1c88_pkg.sv
rtl/s1c88_alu.sv
rtl/s1c88_sequencer.sv
rtl/s1c88_datapath.sv
rtl/s1c88.sv
verification/s1c88_checker.sv
verification/tb_s1c88.sv

// File: rtl/micro_rom.mem
// one 28-bit microcode word per line, from address 0 up
// misc [27:23] dst2 [22:18] src2, bus [27] wr [26:25] mode [24:20] reg, jump [27:25] cond
// common [15:14] type [13:12] alu [11] flags [10] done [9:5] dst [4:0] src
0000400
000002A
0000400
000004A
0000400
00000AA
000008A
0000400
6080161
0001C2D
6080161
0002C2D
6080161
0003C2D
8104000
0000400
0104000
0000400
00001CA
000800E
0000400
00001CA
600800E
0000400
00001CA
800800E
0000400
00001CA
200800E
0000400
00001CA
400800E
0000400

// File: rtl/opcode_map.mem
// opcode address, then the microcode start address of that opcode
@02 08
@0A 0A
@22 0C
@45 10
@78 0E
@B0 01
@B1 03
@C5 05
@E4 15
@E5 18
@E6 1B
@E7 1E
@F1 12

// File: rtl/s1c88.sv
`timescale 1ns/1ps
`default_nettype none

module s1c88
    import s1c88_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic [7:0]  data_in,
    output logic        pk,
    output logic [7:0]  data_out,
    output logic [23:0] address_out,
    output bus_status_t bus_status,
    output logic        read,
    output logic        write,
    output logic        sync,
    output logic        iack
);
    seq_ctrl_t seq_ctrl;

    s1c88_sequencer i_sequencer
    (
        .clk      (clk),
        .reset    (reset),
        .data_in  (data_in),
        .seq_ctrl (seq_ctrl),
        .pk       (pk),
        .sync     (sync),
        .iack     (iack)
    );

    s1c88_datapath i_datapath
    (
        .clk         (clk),
        .reset       (reset),
        .data_in     (data_in),
        .seq_ctrl    (seq_ctrl),
        .address_out (address_out),
        .data_out    (data_out),
        .bus_status  (bus_status),
        .read        (read),
        .write       (write)
    );

endmodule

`default_nettype wire

// File: rtl/s1c88_alu.sv
`timescale 1ns/1ps
`default_nettype none

module s1c88_alu
    import s1c88_pkg::*;
(
    input  alu_op_t    op,
    input  logic [7:0] a,
    input  logic [7:0] b,
    output logic [7:0] result,
    output logic       zero,
    output logic       carry
);
    // one extra bit holds the carry out of ADD and the borrow of SUB
    logic [8:0] wide;

    always_comb
    begin
        case (op)
            ALU_ADD:
            begin
                wide = {1'b0, a} + {1'b0, b};
            end
            ALU_SUB:
            begin
                // a borrow wraps into bit 8
                wide = {1'b0, a} - {1'b0, b};
            end
            ALU_AND:
            begin
                wide = {1'b0, a & b};
            end
            default:
            begin
                wide = {1'b0, a};
            end
        endcase
    end

    assign result = wide[7:0];
    assign carry  = wide[8];
    assign zero   = (wide[7:0] == 8'd0);

endmodule

`default_nettype wire

// File: rtl/s1c88_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module s1c88_datapath
    import s1c88_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic [7:0]  data_in,
    input  seq_ctrl_t   seq_ctrl,
    output logic [23:0] address_out,
    output logic [7:0]  data_out,
    output bus_status_t bus_status,
    output logic        read,
    output logic        write
);
    logic [7:0]    sc;
    logic [7:0]    sc_n;
    logic [15:0]   pc;
    logic [15:0]   pc_n;
    logic [15:0]   top_address;
    logic [15:0]   top_address_n;
    logic [15:0]   ba;
    logic [15:0]   ba_n;
    logic [15:0]   hl;
    logic [15:0]   hl_n;
    logic [15:0]   imm;
    logic [15:0]   imm_n;
    logic [7:0]    alu_a;
    logic [7:0]    alu_a_n;
    logic [7:0]    alu_b;
    logic [7:0]    alu_b_n;
    logic [7:0]    alu_result;
    logic          alu_zero;
    logic          alu_carry;
    logic [15:0]   main_value;
    logic [15:0]   sec_value;
    logic [15:0]   bus_value;
    logic          jump_taken;
    logic          apply_step;
    micro_op_t     micro;
    micro_common_t step;

    assign micro      = seq_ctrl.micro;
    assign step       = micro.misc.common;
    assign apply_step = seq_ctrl.pk && (seq_ctrl.state == STATE_EXECUTE);

    s1c88_alu i_alu
    (
        .op     (step.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .zero   (alu_zero),
        .carry  (alu_carry)
    );

    function automatic logic [15:0] reg_value(input mov_reg_t id);
        case (id)
            MOV_A:     reg_value = {8'd0, ba[7:0]};
            MOV_B:     reg_value = {8'd0, ba[15:8]};
            MOV_BA:    reg_value = ba;
            MOV_H:     reg_value = {8'd0, hl[15:8]};
            MOV_L:     reg_value = {8'd0, hl[7:0]};
            MOV_HL:    reg_value = hl;
            MOV_PCL:   reg_value = {8'd0, pc[7:0]};
            MOV_PCH:   reg_value = {8'd0, pc[15:8]};
            MOV_SC:    reg_value = {8'd0, sc};
            MOV_DATA:  reg_value = {8'd0, data_in};
            MOV_ALU_A: reg_value = {8'd0, alu_a};
            MOV_ALU_B: reg_value = {8'd0, alu_b};
            MOV_ALU_R: reg_value = {8'd0, alu_result};
            MOV_IMML:  reg_value = {8'd0, imm[7:0]};
            MOV_IMMH:  reg_value = {8'd0, imm[15:8]};
            MOV_IMM:   reg_value = imm;
            default:   reg_value = 16'd0;
        endcase
    endfunction

    // DATA and ALU_R are sources only, a write to them is dropped
    task automatic write_reg(input mov_reg_t id, input logic [15:0] value);
        case (id)
            MOV_A:     ba_n[7:0] = value[7:0];
            MOV_B:     ba_n[15:8] = value[7:0];
            MOV_BA:    ba_n = value;
            MOV_H:     hl_n[15:8] = value[7:0];
            MOV_L:     hl_n[7:0] = value[7:0];
            MOV_HL:    hl_n = value;
            MOV_PCL:   pc_n[7:0] = value[7:0];
            MOV_PCH:   pc_n[15:8] = value[7:0];
            MOV_SC:    sc_n = value[7:0];
            MOV_ALU_A: alu_a_n = value[7:0];
            MOV_ALU_B: alu_b_n = value[7:0];
            MOV_IMML:  imm_n[7:0] = value[7:0];
            MOV_IMMH:  imm_n[15:8] = value[7:0];
            MOV_IMM:   imm_n = value;
            default:   ;
        endcase
    endtask

    always_comb
    begin
        main_value = reg_value(step.src);
        sec_value  = reg_value(micro.misc.src_sec);
        bus_value  = reg_value(micro.bus.bus_reg);
        case (micro.jump.cond)
            COND_NONE: jump_taken = 1'b1;
            COND_C:    jump_taken = sc[FLAG_CARRY];
            COND_NC:   jump_taken = !sc[FLAG_CARRY];
            COND_Z:    jump_taken = sc[FLAG_ZERO];
            COND_NZ:   jump_taken = !sc[FLAG_ZERO];
            default:   jump_taken = 1'b0;
        endcase
    end

    // everything changes at the edge that ends the data phase
    always_comb
    begin
        sc_n          = sc;
        pc_n          = pc;
        top_address_n = top_address;
        ba_n          = ba;
        hl_n          = hl;
        imm_n         = imm;
        alu_a_n       = alu_a;
        alu_b_n       = alu_b;
        if (seq_ctrl.pk && seq_ctrl.state == STATE_VECTOR)
        begin
            if (seq_ctrl.vector_step[0])
                pc_n[15:8] = data_in;
            else
                pc_n[7:0] = data_in;
        end
        if (apply_step)
        begin
            if (seq_ctrl.fetch)
            begin
                top_address_n = pc;
                pc_n          = pc + 16'd1;
            end
            else if (step.src == MOV_DATA)
            begin
                pc_n = pc + 16'd1;
            end
            if (step.micro_type == MICRO_MISC)
                write_reg(micro.misc.dst_sec, sec_value);
            else if (step.micro_type == MICRO_BUS && !micro.bus.write)
                write_reg(micro.bus.bus_reg, {8'd0, data_in});
            write_reg(step.dst, main_value);
            if (step.flag_write)
            begin
                sc_n[FLAG_ZERO] = alu_zero;
                // AND leaves the carry as it was
                if (step.alu_op != ALU_AND)
                    sc_n[FLAG_CARRY] = alu_carry;
            end
            if (step.micro_type == MICRO_JUMP && jump_taken)
                pc_n = top_address + 16'd2 + {{8{main_value[7]}}, main_value[7:0]};
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            sc          <= SC_RESET_VALUE;
            pc          <= 16'd0;
            top_address <= 16'd0;
        end
        else
        begin
            sc          <= sc_n;
            pc          <= pc_n;
            top_address <= top_address_n;
        end
    end

    always_ff @(posedge clk)
    begin
        ba    <= ba_n;
        hl    <= hl_n;
        imm   <= imm_n;
        alu_a <= alu_a_n;
        alu_b <= alu_b_n;
    end

    // the opcode fetch wins over any bus request of the done step
    always_comb
    begin
        address_out = '1;
        bus_status  = BUS_IDLE;
        data_out    = bus_value[7:0];
        case (seq_ctrl.state)
            STATE_VECTOR:
            begin
                address_out = {8'd0, 14'd0, seq_ctrl.vector_step};
                bus_status  = BUS_MEM_READ;
            end
            STATE_EXECUTE:
            begin
                address_out = {8'd0, pc};
                if (seq_ctrl.fetch)
                begin
                    bus_status = BUS_MEM_READ;
                end
                else if (step.micro_type == MICRO_BUS)
                begin
                    address_out = {8'd0, (micro.bus.addr_mode == ADDR_HL) ? hl : imm};
                    bus_status  = micro.bus.write ? BUS_MEM_WRITE : BUS_MEM_READ;
                end
                else if (step.src == MOV_DATA)
                begin
                    bus_status = BUS_MEM_READ;
                end
            end
            default:
            begin
            end
        endcase
    end

    assign read  = !seq_ctrl.pk && (bus_status == BUS_MEM_READ);
    assign write = !seq_ctrl.pk && (bus_status == BUS_MEM_WRITE);

endmodule

`default_nettype wire

// File: rtl/s1c88_pkg.sv
`default_nettype none

package s1c88_pkg;

    localparam int MICRO_ROM_DEPTH  = 64;
    localparam int OPCODE_MAP_DEPTH = 256;
    localparam int MICRO_ADDR_W     = $clog2(MICRO_ROM_DEPTH);

    // bit positions of the flags inside SC
    localparam int FLAG_ZERO  = 0;
    localparam int FLAG_CARRY = 1;

    // both interrupt mask bits come up set
    localparam logic [7:0] SC_RESET_VALUE = 8'hC0;
    localparam logic [1:0] RESET_DELAY    = 2'd2;

    typedef enum logic [1:0] {
        BUS_IDLE      = 2'd0,
        BUS_MEM_WRITE = 2'd2,
        BUS_MEM_READ  = 2'd3
    } bus_status_t;

    typedef enum logic [1:0] {
        STATE_IDLE    = 2'd0,
        STATE_VECTOR  = 2'd1,
        STATE_EXECUTE = 2'd2
    } seq_state_t;

    typedef enum logic [1:0] {
        MICRO_MISC = 2'd0,
        MICRO_BUS  = 2'd1,
        MICRO_JUMP = 2'd2
    } micro_type_t;

    // register selectors shared by the move and bus fields of the microcode
    typedef enum logic [4:0] {
        MOV_NONE  = 5'h00,
        MOV_A     = 5'h01,
        MOV_B     = 5'h02,
        MOV_BA    = 5'h03,
        MOV_H     = 5'h04,
        MOV_L     = 5'h05,
        MOV_HL    = 5'h06,
        MOV_PCL   = 5'h07,
        MOV_PCH   = 5'h08,
        MOV_SC    = 5'h09,
        MOV_DATA  = 5'h0A,
        MOV_ALU_A = 5'h0B,
        MOV_ALU_B = 5'h0C,
        MOV_ALU_R = 5'h0D,
        MOV_IMML  = 5'h0E,
        MOV_IMMH  = 5'h0F,
        MOV_IMM   = 5'h10
    } mov_reg_t;

    typedef enum logic [1:0] {
        ADDR_HL  = 2'd0,
        ADDR_IMM = 2'd1
    } bus_addr_mode_t;

    typedef enum logic [1:0] {
        ALU_NONE = 2'd0,
        ALU_ADD  = 2'd1,
        ALU_SUB  = 2'd2,
        ALU_AND  = 2'd3
    } alu_op_t;

    typedef enum logic [2:0] {
        COND_NONE = 3'd0,
        COND_C    = 3'd1,
        COND_NC   = 3'd2,
        COND_Z    = 3'd3,
        COND_NZ   = 3'd4
    } jump_cond_t;

    // low 16 bits of every microcode word, in all three views
    // [15:14] type, [13:12] alu op, [11] flag write, [10] done, [9:5] dst, [4:0] src
    typedef struct packed {
        micro_type_t micro_type;
        alu_op_t     alu_op;
        logic        flag_write;
        logic        done;
        mov_reg_t    dst;
        mov_reg_t    src;
    } micro_common_t;

    // misc view: [27:23] second dst, [22:18] second src
    typedef struct packed {
        mov_reg_t      dst_sec;
        mov_reg_t      src_sec;
        logic [1:0]    spare;
        micro_common_t common;
    } micro_misc_t;

    // bus view: [27] write, [26:25] address mode, [24:20] bus register
    typedef struct packed {
        logic           write;
        bus_addr_mode_t addr_mode;
        mov_reg_t       bus_reg;
        logic [3:0]     spare;
        micro_common_t  common;
    } micro_bus_t;

    // jump view: [27:25] condition, the offset is the value of the main source
    typedef struct packed {
        jump_cond_t    cond;
        logic [8:0]    spare;
        micro_common_t common;
    } micro_jump_t;

    typedef union packed {
        micro_misc_t misc;
        micro_bus_t  bus;
        micro_jump_t jump;
    } micro_op_t;

    localparam int MICRO_WIDTH = $bits(micro_op_t);

    typedef struct packed {
        logic       pk;
        seq_state_t state;
        logic       fetch;
        logic [1:0] vector_step;
        micro_op_t  micro;
    } seq_ctrl_t;

endpackage

`default_nettype wire

// File: rtl/s1c88_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module s1c88_sequencer
    import s1c88_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] data_in,
    output seq_ctrl_t  seq_ctrl,
    output logic       pk,
    output logic       sync,
    output logic       iack
);
    logic [MICRO_ADDR_W-1:0] opcode_map [OPCODE_MAP_DEPTH];
    logic [MICRO_WIDTH-1:0]  micro_rom [MICRO_ROM_DEPTH];

    seq_state_t              state;
    logic [1:0]              reset_count;
    logic [1:0]              vector_step;
    logic [3:0]              micro_step;
    logic [7:0]              opcode;
    logic [MICRO_ADDR_W-1:0] micro_addr;
    micro_op_t               micro_op;
    logic                    done;
    logic                    fetch;

    // unmapped opcodes and unused words read as zero, so they land on the nop
    initial
    begin
        foreach (opcode_map[i])
            opcode_map[i] = '0;
        foreach (micro_rom[i])
            micro_rom[i] = '0;
        $readmemh("rtl/opcode_map.mem", opcode_map);
        $readmemh("rtl/micro_rom.mem", micro_rom);
    end

    // the start address of the instruction plus the step inside it
    assign micro_addr = opcode_map[opcode] + MICRO_ADDR_W'(micro_step);
    assign micro_op   = micro_op_t'(micro_rom[micro_addr]);
    assign done       = micro_op.misc.common.done;

    // the done step always shares its bus cycle with the next opcode fetch
    assign fetch = (state == STATE_EXECUTE) && done;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            pk          <= 1'b0;
            state       <= STATE_IDLE;
            reset_count <= 2'd0;
            vector_step <= 2'd0;
            micro_step  <= 4'd0;
            opcode      <= 8'h00;
        end
        else
        begin
            case (state)
                STATE_IDLE:
                begin
                    reset_count <= reset_count + 2'd1;
                    if (reset_count == RESET_DELAY - 2'd1)
                        state <= STATE_VECTOR;
                end
                STATE_VECTOR:
                begin
                    pk <= ~pk;
                    // step 0 reads the low PC byte, step 1 the high byte
                    if (pk)
                    begin
                        vector_step <= vector_step + 2'd1;
                        if (vector_step == 2'd1)
                            state <= STATE_EXECUTE;
                    end
                end
                STATE_EXECUTE:
                begin
                    pk <= ~pk;
                    if (pk)
                    begin
                        if (done)
                        begin
                            opcode     <= data_in;
                            micro_step <= 4'd0;
                        end
                        else
                        begin
                            micro_step <= micro_step + 4'd1;
                        end
                    end
                end
                default:
                begin
                    state <= STATE_IDLE;
                end
            endcase
        end
    end

    assign sync = fetch && !pk;
    assign iack = (state == STATE_VECTOR);

    assign seq_ctrl.pk          = pk;
    assign seq_ctrl.state       = state;
    assign seq_ctrl.fetch       = fetch;
    assign seq_ctrl.vector_step = vector_step;
    assign seq_ctrl.micro       = micro_op;

endmodule

`default_nettype wire

// File: verification/s1c88_checker.sv
`timescale 1ns/1ps
`default_nettype none

module s1c88_checker
    import s1c88_pkg::*;
(
    input wire logic        clk,
    input wire logic        reset,
    input wire logic        pk,
    input wire logic        read,
    input wire logic        write,
    input wire logic        sync,
    input wire logic        iack,
    input wire bus_status_t bus_status,
    input wire logic [23:0] address_out
);
    // set once the vector reads begin, which ends the reset delay
    logic bus_started;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            bus_started <= 1'b0;
        else if (iack)
            bus_started <= 1'b1;
    end

    a_read_write_exclusive : assert property (@(posedge clk) disable iff (reset)
        !(read && write))
        else $error("read and write are high in the same clock");

    a_write_status : assert property (@(posedge clk) disable iff (reset)
        write |-> (bus_status == BUS_MEM_WRITE))
        else $error("write is high without a memory write bus status");

    a_sync_read : assert property (@(posedge clk) disable iff (reset)
        sync |-> read)
        else $error("sync is high without read");

    // strobes belong to the address phase only
    a_strobe_phase : assert property (@(posedge clk) disable iff (reset)
        (read || write) |-> !pk)
        else $error("read or write is high in the data phase");

    // the code bank is gone, so every access stays in the first 64 KiB
    a_upper_zero : assert property (@(posedge clk) disable iff (reset)
        (iack || bus_started) |-> (address_out[23:16] == 8'h00))
        else $error("upper address byte is not zero after the reset delay");

    a_vector_address : assert property (@(posedge clk) disable iff (reset)
        (iack && read) |-> (address_out[23:1] == 23'd0))
        else $error("vector read outside addresses 0 and 1");

    a_iack_no_sync : assert property (@(posedge clk) disable iff (reset)
        iack |-> !sync)
        else $error("opcode fetch during the vector reads");

endmodule

bind s1c88 s1c88_checker i_checker (.*);

`default_nettype wire

// File: verification/tb_s1c88.sv
`timescale 1ns/1ps
`default_nettype none

module tb_s1c88;
    import s1c88_pkg::*;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;
    } write_rec_t;

    localparam int RUN_LIMIT = 20000;

    logic        clk;
    logic        reset;
    logic [7:0]  data_in;
    logic        pk;
    logic [7:0]  data_out;
    logic [23:0] address_out;
    bus_status_t bus_status;
    logic        read;
    logic        write;
    logic        sync;
    logic        iack;

    logic [7:0]  mem [65536];
    logic [15:0] build_pc;
    logic [15:0] final_addr;
    logic [31:0] rnd_state;
    logic [15:0] sync_q [$];
    write_rec_t  write_q [$];
    int          vector_reads;
    int          loop_syncs;
    logic        sync_seen;
    logic        program_done;

    s1c88 i_s1c88
    (
        .clk         (clk),
        .reset       (reset),
        .data_in     (data_in),
        .pk          (pk),
        .data_out    (data_out),
        .address_out (address_out),
        .bus_status  (bus_status),
        .read        (read),
        .write       (write),
        .sync        (sync),
        .iack        (iack)
    );

    // the memory answers within the same clock
    assign data_in = mem[address_out[15:0]];

    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        if (write)
            mem[address_out[15:0]] = data_out;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic fail_run(input string text);
        $display("%s", text);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic random_byte(output logic [7:0] value);
        rnd_state = xorshift32(rnd_state);
        value = rnd_state[7:0];
    endtask

    task automatic emit(input logic [7:0] value);
        mem[build_pc] = value;
        build_pc = build_pc + 16'd1;
    endtask

    // every instruction that runs shows up as one sync at its opcode address
    task automatic op_plain(input logic [7:0] opc);
        sync_q.push_back(build_pc);
        emit(opc);
    endtask

    task automatic op_imm8(input logic [7:0] opc, input logic [7:0] value);
        op_plain(opc);
        emit(value);
    endtask

    task automatic load_hl(input logic [15:0] addr);
        op_plain(8'hC5);
        emit(addr[7:0]);
        emit(addr[15:8]);
    endtask

    task automatic store_a(input logic [15:0] addr, input logic [7:0] value);
        load_hl(addr);
        op_plain(8'h78);
        write_q.push_back('{addr: addr, data: value});
    endtask

    // a jump over two filler loads, so the target is the jump address plus six
    task automatic jump_over(input logic [7:0] opc, input logic taken);
        op_imm8(opc, 8'h04);
        if (taken)
        begin
            emit(8'hB0);
            emit(8'h00);
            emit(8'hB0);
            emit(8'h00);
        end
        else
        begin
            op_imm8(8'hB0, 8'h00);
            op_imm8(8'hB0, 8'h00);
        end
    endtask

    task automatic arith_case(input logic [7:0] opc, input logic [7:0] a,
                              input logic [7:0] b, input logic [15:0] dest);
        logic [7:0] expected;
        case (opc)
            8'h02:   expected = a + b;
            8'h0A:   expected = a - b;
            default: expected = a & b;
        endcase
        op_imm8(8'hB0, a);
        op_imm8(8'hB1, b);
        op_plain(opc);
        store_a(dest, expected);
    endtask

    // after a - b, zero means equal and carry means a borrow
    task automatic jump_round(input logic [7:0] x, input logic [7:0] y);
        logic z;
        logic c;
        z = (x == y);
        c = (x < y);
        op_imm8(8'hB0, x);
        op_imm8(8'hB1, y);
        op_plain(8'h0A);
        jump_over(8'hE4, z);
        jump_over(8'hE5, !z);
        jump_over(8'hE6, c);
        jump_over(8'hE7, !c);
    endtask

    task automatic build_program();
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] r;
        logic [7:0] placed;
        logic [15:0] vector;
        for (int i = 0; i < 65536; i++)
            mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5A;
        random_byte(r);
        vector = 16'h1000 + {4'h0, r, 4'h0};
        mem[0] = vector[7:0];
        mem[1] = vector[15:8];
        build_pc = vector;
        random_byte(a);
        random_byte(b);
        random_byte(placed);
        random_byte(r);
        arith_case(8'h02, a, b, 16'h8100 + {8'h00, r});
        arith_case(8'h0A, a, b, 16'h8200 + {8'h00, r});
        arith_case(8'h22, a, b, 16'h8300 + {8'h00, r});
        jump_round(a, b);
        jump_round(b, a);
        jump_round(a, a);
        jump_over(8'hF1, 1'b1);
        mem[16'h8400 + {8'h00, r}] = placed;
        load_hl(16'h8400 + {8'h00, r});
        op_plain(8'h45);
        store_a(16'h8500 + {8'h00, r}, placed);
        final_addr = build_pc;
        op_imm8(8'hF1, 8'hFE);
    endtask

    always @(negedge clk)
    begin
        if (!reset && vector_reads < 2)
        begin
            assert (!write && !sync)
                else fail_run("bus write or opcode fetch before the vector reads");
            if (read)
            begin
                assert (iack) else fail_run("vector read without iack");
                assert (address_out == 24'(vector_reads))
                    else fail_run($sformatf("error address_out: expected %h, got %h",
                                            24'(vector_reads), address_out));
                vector_reads = vector_reads + 1;
            end
            else if (vector_reads == 0)
            begin
                assert (!iack && !pk) else fail_run("bus phase started before the vector reads");
            end
        end
        if (sync_seen)
        begin
            assert (!iack) else fail_run("iack still high after the first opcode fetch");
        end
        if (sync)
        begin
            sync_seen = 1'b1;
            if (sync_q.size() > 0)
            begin
                assert (address_out[15:0] == sync_q[0])
                    else fail_run($sformatf("error address_out: expected %h, got %h",
                                            sync_q[0], address_out[15:0]));
                void'(sync_q.pop_front());
            end
            else
            begin
                assert (address_out[15:0] == final_addr)
                    else fail_run($sformatf("error address_out: expected %h, got %h",
                                            final_addr, address_out[15:0]));
                loop_syncs = loop_syncs + 1;
                if (loop_syncs >= 2)
                    program_done = 1'b1;
            end
        end
        if (write)
        begin
            assert (write_q.size() > 0) else fail_run("a write that the program does not make");
            assert (address_out[15:0] == write_q[0].addr)
                else fail_run($sformatf("error address_out: expected %h, got %h",
                                        write_q[0].addr, address_out[15:0]));
            assert (data_out == write_q[0].data)
                else fail_run($sformatf("error data_out: expected %h, got %h",
                                        write_q[0].data, data_out));
            void'(write_q.pop_front());
        end
    end

    initial
    begin
        int cycles;
        clk          = 1'b0;
        reset        = 1'b1;
        rnd_state    = 32'd42;
        vector_reads = 0;
        loop_syncs   = 0;
        sync_seen    = 1'b0;
        program_done = 1'b0;
        build_program();
        repeat (5) @(negedge clk);
        reset = 1'b0;
        cycles = 0;
        while (!program_done && cycles < RUN_LIMIT)
        begin
            @(negedge clk);
            cycles = cycles + 1;
        end
        if (!program_done)
            fail_run("timeout waiting for the final self-jump");
        else if (write_q.size() != 0)
            fail_run("the program ended with stores that never happened");
        else
        begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire
